/* alu_cluster_top.f */
design/alu_pkg.sv
design/cluster_pkg.sv
design/lane_if.sv
design/core_detachable_alu.sv
design/operand_dispatch.sv
design/exec_lane.sv
design/writeback_regfile.sv
design/alu_cluster_top.sv
dv/tb_clock_gen.sv
dv/tb_alu_cluster.sv

/* Bender.yml */
package:
  name: alu_cluster

sources:
  # packages first, then interface and modules bottom up
  - design/alu_pkg.sv
  - design/cluster_pkg.sv
  - design/lane_if.sv
  - design/core_detachable_alu.sv
  - design/operand_dispatch.sv
  - design/exec_lane.sv
  - design/writeback_regfile.sv
  - design/alu_cluster_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_alu_cluster.sv

/* dv/tb_alu_cluster.sv */
`timescale 1ns/1ns

module tb_alu_cluster;
  import alu_pkg::*;
  import cluster_pkg::*;

  // about 100 cycles of tests, limit with a wide margin
  localparam int EST_CYCLES = 100;
  localparam int MAX_CYCLES = 4 * EST_CYCLES;

  logic                         clk;
  logic                         rst_n;
  logic [LANES-1:0]             slot_valid;
  logic [LANES-1:0][1:0]        slot_grand_op;
  logic [LANES-1:0][1:0]        slot_op;
  logic [LANES-1:0][REG_AW-1:0] slot_rd;
  logic [LANES-1:0][REG_AW-1:0] slot_rs1;
  logic [LANES-1:0][REG_AW-1:0] slot_rs2;
  logic [LANES-1:0]             slot_use_imm;
  logic [LANES-1:0][XLEN-1:0]   slot_imm;
  logic [REG_AW-1:0]            rd_addr;
  logic [XLEN-1:0]              rd_data;
  logic [LANES-1:0]             commit_valid;
  logic [LANES-1:0][REG_AW-1:0] commit_rd;
  logic [LANES-1:0][XLEN-1:0]   commit_data;

  // bundle being built, goes out on the next issue
  issue_slot_t [LANES-1:0]      stage;
  logic [REG_AW-1:0]            probe;
  // program-order model, source of expected results
  logic [XLEN-1:0]              spec_regs [NREGS];
  // committed model, what the read port should show
  logic [XLEN-1:0]              arch_regs [NREGS];
  // expected commits, slot picked by the cycle they show up
  logic [LANES-1:0]             exp_valid [4];
  logic [LANES-1:0][REG_AW-1:0] exp_rd [4];
  logic [LANES-1:0][XLEN-1:0]   exp_data [4];
  integer                       seed = 34;
  int                           cyc;
  int                           err_count;
  int                           err_base;
  int                           tests_passed;
  int                           tests_failed;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  alu_cluster_top dut0 (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .slot_valid_i    (slot_valid),
    .slot_grand_op_i (slot_grand_op),
    .slot_op_i       (slot_op),
    .slot_rd_i       (slot_rd),
    .slot_rs1_i      (slot_rs1),
    .slot_rs2_i      (slot_rs2),
    .slot_use_imm_i  (slot_use_imm),
    .slot_imm_i      (slot_imm),
    .rd_addr_i       (rd_addr),
    .rd_data_o       (rd_data),
    .commit_valid_o  (commit_valid),
    .commit_rd_o     (commit_rd),
    .commit_data_o   (commit_data)
  );

  // cycle count and run limit
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > MAX_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cyc);
      $display("Testbench failed");
      $finish;
    end
  end

  // operation semantics, a is rs1 and b the second operand
  function automatic logic [XLEN-1:0] expected_result(
    input logic [1:0]      gop,
    input logic [1:0]      op,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
  );
    logic [4:0] sh;
    sh = b[4:0];
    case (gop)
      GTYPE_LOGIC: begin
        case (op)
          STYPE_NOR: return ~(a | b);
          STYPE_AND: return a & b;
          STYPE_OR:  return a | b;
          default:   return a ^ b;
        endcase
      end
      GTYPE_INT: return (op == STYPE_SUB) ? a - b : a + b;
      GTYPE_SFT: begin
        case (op)
          STYPE_SRL: return a >> sh;
          STYPE_SRA: return $signed(a) >>> sh;
          default:   return a << sh;
        endcase
      end
      // compare, 0 or 1
      default: return (op == STYPE_SLTU) ? XLEN'(a < b) : XLEN'($signed(a) < $signed(b));
    endcase
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  // a register among the loaded ones, 1..16
  function automatic logic [REG_AW-1:0] rand_reg();
    return REG_AW'(1 + {$random(seed)} % 16);
  endfunction

  task automatic report_mismatch(
    input string           name,
    input logic [XLEN-1:0] exp,
    input logic [XLEN-1:0] got
  );
    err_count++;
    $display("Fail at %0t ns: %s expected %h, observed %h", $time, name, exp, got);
  endtask

  task automatic set_slot(
    input int                lane,
    input logic [1:0]        gop,
    input logic [1:0]        op,
    input logic [REG_AW-1:0] rd,
    input logic [REG_AW-1:0] rs1,
    input logic [REG_AW-1:0] rs2,
    input logic              use_imm,
    input logic [XLEN-1:0]   imm
  );
    stage[lane] = '{1'b1, gop, op, rd, rs1, rs2, use_imm, imm};
  endtask

  // one clock of stimulus, expected commit lands two edges later
  task automatic issue_cycle();
    logic [LANES-1:0][XLEN-1:0] res;
    logic [XLEN-1:0]            opnd;
    int                         idx;
    @(posedge clk);
    #1;
    idx = (cyc + 2) % 4;
    for (int l = 0; l < LANES; l++) begin
      opnd = stage[l].use_imm ? stage[l].imm : spec_regs[stage[l].rs2];
      res[l] = expected_result(stage[l].grand_op, stage[l].op, spec_regs[stage[l].rs1], opnd);
      // r0 never holds a result
      if (stage[l].rd == '0) begin
        res[l] = '0;
      end
      slot_valid[l]    = stage[l].valid;
      slot_grand_op[l] = stage[l].grand_op;
      slot_op[l]       = stage[l].op;
      slot_rd[l]       = stage[l].rd;
      slot_rs1[l]      = stage[l].rs1;
      slot_rs2[l]      = stage[l].rs2;
      slot_use_imm[l]  = stage[l].use_imm;
      slot_imm[l]      = stage[l].imm;
      exp_valid[idx][l] = stage[l].valid;
      exp_rd[idx][l]    = stage[l].rd;
      exp_data[idx][l]  = res[l];
      if (stage[l].valid) begin
        probe = stage[l].rd;
      end
    end
    // whole bundle read old state, now lanes write in order
    for (int l = 0; l < LANES; l++) begin
      if (stage[l].valid && stage[l].rd != '0) begin
        spec_regs[stage[l].rd] = res[l];
      end
    end
    rd_addr = probe;
    stage = '0;
  endtask

  // drain the pipe, then the per-test line
  task automatic finish_test(input string name);
    repeat (3) issue_cycle();
    if (err_count == err_base) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, err_count - err_base);
    end
    err_base = err_count;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin : check_outputs
    int idx;
    if (rst_n) begin
      idx = cyc % 4;
      for (int l = 0; l < LANES; l++) begin
        assert (commit_valid[l] === exp_valid[idx][l])
          else report_mismatch($sformatf("commit_valid_o[%0d]", l), exp_valid[idx][l],
                               commit_valid[l]);
        if (exp_valid[idx][l]) begin
          assert (commit_rd[l] === exp_rd[idx][l])
            else report_mismatch($sformatf("commit_rd_o[%0d]", l), exp_rd[idx][l], commit_rd[l]);
          assert (commit_data[l] === exp_data[idx][l])
            else report_mismatch($sformatf("commit_data_o[%0d]", l), exp_data[idx][l],
                                 commit_data[l]);
          // higher lane applied last
          if (exp_rd[idx][l] != '0) begin
            arch_regs[exp_rd[idx][l]] = exp_data[idx][l];
          end
        end
      end
      exp_valid[idx] = '0;
      assert (rd_data === arch_regs[rd_addr])
        else report_mismatch("rd_data_o", arch_regs[rd_addr], rd_data);
    end
  end

  initial begin
    slot_valid    = '0;
    slot_grand_op = '0;
    slot_op       = '0;
    slot_rd       = '0;
    slot_rs1      = '0;
    slot_rs2      = '0;
    slot_use_imm  = '0;
    slot_imm      = '0;
    rd_addr       = '0;
    stage         = '0;
    probe         = '0;
    for (int r = 0; r < NREGS; r++) begin
      spec_regs[r] = '0;
      arch_regs[r] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      exp_valid[i] = '0;
    end
    wait (rst_n === 1'b1);

    // no commits, every register reads zero
    for (int r = 0; r < NREGS; r++) begin
      probe = REG_AW'(r);
      issue_cycle();
    end
    finish_test("reset");

    // fill r1..r16 with random words
    for (int r = 1; r <= 16; r += 2) begin
      set_slot(0, GTYPE_INT, STYPE_ADD, REG_AW'(r), 5'd0, 5'd0, 1'b1, rand_word());
      set_slot(1, GTYPE_INT, STYPE_ADD, REG_AW'(r + 1), 5'd0, 5'd0, 1'b1, rand_word());
      issue_cycle();
    end
    set_slot(0, GTYPE_LOGIC, STYPE_NOR, 5'd17, rand_reg(), rand_reg(), 1'b0, '0);
    set_slot(1, GTYPE_LOGIC, STYPE_AND, 5'd18, rand_reg(), rand_reg(), 1'b0, '0);
    issue_cycle();
    set_slot(0, GTYPE_LOGIC, STYPE_OR, 5'd19, rand_reg(), rand_reg(), 1'b0, '0);
    set_slot(1, GTYPE_LOGIC, STYPE_XOR, 5'd20, rand_reg(), rand_reg(), 1'b0, '0);
    issue_cycle();
    finish_test("logic");

    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd26, rand_reg(), rand_reg(), 1'b0, '0);
    set_slot(1, GTYPE_INT, STYPE_SUB, 5'd27, rand_reg(), rand_reg(), 1'b0, '0);
    issue_cycle();
    // sources still in the lanes, bypass only
    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd28, 5'd26, 5'd27, 1'b0, '0);
    set_slot(1, GTYPE_INT, STYPE_SUB, 5'd29, 5'd27, 5'd26, 1'b0, '0);
    issue_cycle();
    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd30, 5'd28, 5'd0, 1'b1, rand_word());
    set_slot(1, GTYPE_INT, STYPE_SUB, 5'd31, 5'd29, 5'd28, 1'b0, '0);
    issue_cycle();
    finish_test("add_sub");

    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd21, 5'd0, 5'd0, 1'b1, 32'h8123_4567);
    set_slot(1, GTYPE_INT, STYPE_ADD, 5'd22, 5'd0, 5'd0, 1'b1, rand_word());
    issue_cycle();
    // random amounts, upper bits ignored
    set_slot(0, GTYPE_SFT, STYPE_SLL, 5'd23, 5'd22, 5'd0, 1'b1, rand_word());
    set_slot(1, GTYPE_SFT, STYPE_SRA, 5'd24, 5'd21, 5'd0, 1'b1, 32'd7);
    issue_cycle();
    set_slot(0, GTYPE_SFT, STYPE_SRL, 5'd25, 5'd21, 5'd0, 1'b1, 32'd12);
    set_slot(1, GTYPE_SFT, STYPE_SRA, 5'd23, 5'd22, 5'd0, 1'b1, rand_word());
    issue_cycle();
    finish_test("shift");

    // negative vs positive, signed and unsigned orders disagree
    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd11, 5'd0, 5'd0, 1'b1, rand_word() | 32'h8000_0000);
    set_slot(1, GTYPE_INT, STYPE_ADD, 5'd12, 5'd0, 5'd0, 1'b1, rand_word() & 32'h7fff_ffff);
    issue_cycle();
    set_slot(0, GTYPE_CMP, STYPE_SLT, 5'd13, 5'd11, 5'd12, 1'b0, '0);
    set_slot(1, GTYPE_CMP, STYPE_SLTU, 5'd14, 5'd11, 5'd12, 1'b0, '0);
    issue_cycle();
    set_slot(0, GTYPE_CMP, STYPE_SLT, 5'd15, 5'd12, 5'd11, 1'b0, '0);
    set_slot(1, GTYPE_CMP, STYPE_SLTU, 5'd16, 5'd12, 5'd11, 1'b0, '0);
    issue_cycle();
    finish_test("compare");

    // both lanes hit r5
    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd5, 5'd0, 5'd0, 1'b1, rand_word());
    set_slot(1, GTYPE_LOGIC, STYPE_XOR, 5'd5, 5'd3, 5'd0, 1'b1, rand_word());
    issue_cycle();
    // r5 still in both lanes, bypass has to take lane 1
    set_slot(0, GTYPE_INT, STYPE_ADD, 5'd6, 5'd0, 5'd5, 1'b0, '0);
    issue_cycle();
    // r0 targets commit but change nothing
    set_slot(0, GTYPE_LOGIC, STYPE_OR, 5'd0, 5'd1, 5'd2, 1'b0, '0);
    set_slot(1, GTYPE_INT, STYPE_ADD, 5'd0, 5'd5, 5'd0, 1'b1, rand_word());
    issue_cycle();
    probe = '0;
    repeat (2) issue_cycle();
    probe = 5'd5;
    issue_cycle();
    finish_test("same_rd");

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset low for 10 rising edges, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* design/alu_cluster_top.sv */
`timescale 1ns/1ns

module alu_cluster_top (
  input  logic                                               clk,
  input  logic                                               rst_n_i,
  input  logic [cluster_pkg::LANES-1:0]                      slot_valid_i,
  input  logic [cluster_pkg::LANES-1:0][1:0]                 slot_grand_op_i,
  input  logic [cluster_pkg::LANES-1:0][1:0]                 slot_op_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0] slot_rd_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0] slot_rs1_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0] slot_rs2_i,
  input  logic [cluster_pkg::LANES-1:0]                      slot_use_imm_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::XLEN-1:0]   slot_imm_i,
  input  logic [alu_pkg::REG_AW-1:0]                         rd_addr_i,
  output logic [alu_pkg::XLEN-1:0]                           rd_data_o,
  output logic [cluster_pkg::LANES-1:0]                      commit_valid_o,
  output logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0] commit_rd_o,
  output logic [cluster_pkg::LANES-1:0][alu_pkg::XLEN-1:0]   commit_data_o
);
  import alu_pkg::*;
  import cluster_pkg::*;

  issue_slot_t [LANES-1:0]            slots;
  logic [RF_RPORTS-1:0][REG_AW-1:0]   rf_addr;
  logic [RF_RPORTS-1:0][XLEN-1:0]     rf_data;
  logic [LANES-1:0]                   wb_valid;
  logic [LANES-1:0][REG_AW-1:0]       wb_rd;
  logic [LANES-1:0][XLEN-1:0]         wb_data;

  // issue stage to lane, one per lane
  lane_if lanes [LANES] ();

  // gather the flat slot ports into bundle slots
  for (genvar s = 0; s < LANES; s++) begin : g_pack
    assign slots[s] = '{
      valid:    slot_valid_i[s],
      grand_op: slot_grand_op_i[s],
      op:       slot_op_i[s],
      rd:       slot_rd_i[s],
      rs1:      slot_rs1_i[s],
      rs2:      slot_rs2_i[s],
      use_imm:  slot_use_imm_i[s],
      imm:      slot_imm_i[s]
    };
  end

  operand_dispatch u_dispatch (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .slots_i    (slots),
    .rf_data_i  (rf_data),
    .rf_addr_o  (rf_addr),
    .wb_valid_i (wb_valid),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data),
    .lane_o     (lanes)
  );

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    exec_lane u_lane (
      .lane_i     (lanes[l]),
      .wb_valid_o (wb_valid[l]),
      .wb_rd_o    (wb_rd[l]),
      .wb_data_o  (wb_data[l])
    );
  end

  writeback_regfile u_wb (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .wb_valid_i     (wb_valid),
    .wb_rd_i        (wb_rd),
    .wb_data_i      (wb_data),
    .rf_addr_i      (rf_addr),
    .rf_data_o      (rf_data),
    .rd_addr_i      (rd_addr_i),
    .rd_data_o      (rd_data_o),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

endmodule

/* design/writeback_regfile.sv */
`timescale 1ns/1ns

module writeback_regfile (
  input  logic                                                   clk,
  input  logic                                                   rst_n_i,
  input  logic [cluster_pkg::LANES-1:0]                          wb_valid_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0]     wb_rd_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::XLEN-1:0]       wb_data_i,
  input  logic [cluster_pkg::RF_RPORTS-1:0][alu_pkg::REG_AW-1:0] rf_addr_i,
  output logic [cluster_pkg::RF_RPORTS-1:0][alu_pkg::XLEN-1:0]   rf_data_o,
  input  logic [alu_pkg::REG_AW-1:0]                             rd_addr_i,
  output logic [alu_pkg::XLEN-1:0]                               rd_data_o,
  output logic [cluster_pkg::LANES-1:0]                          commit_valid_o,
  output logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0]     commit_rd_o,
  output logic [cluster_pkg::LANES-1:0][alu_pkg::XLEN-1:0]       commit_data_o
);
  import alu_pkg::*;
  import cluster_pkg::*;

  logic [NREGS-1:0][XLEN-1:0] regs;

  // lanes applied in ascending order, last write wins
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      regs <= '0;
    end else begin
      for (int l = 0; l < LANES; l++) begin
        if (wb_valid_i[l]) begin
          regs[wb_rd_i[l]] <= wb_data_i[l];
        end
      end
      // r0 hardwired to zero
      regs[0] <= '0;
    end
  end

  // source reads for dispatch, bypass is applied there
  always_comb begin
    for (int p = 0; p < RF_RPORTS; p++) begin
      rf_data_o[p] = regs[rf_addr_i[p]];
    end
  end

  // architectural read port, committed state only
  assign rd_data_o = regs[rd_addr_i];

  // commit strobes
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      commit_valid_o <= '0;
    end else begin
      commit_valid_o <= wb_valid_i;
    end
  end

  // commit payload follows the strobe
  always_ff @(posedge clk) begin
    commit_rd_o   <= wb_rd_i;
    commit_data_o <= wb_data_i;
  end

endmodule

/* design/exec_lane.sv */
`timescale 1ns/1ns

module exec_lane (
  lane_if.exec                       lane_i,
  output logic                       wb_valid_o,
  output logic [alu_pkg::REG_AW-1:0] wb_rd_o,
  output logic [alu_pkg::XLEN-1:0]   wb_data_o
);
  import alu_pkg::*;

  logic [XLEN-1:0] alu_res;

  // integer build, no pc or multiplier behind this lane
  // no registered group, so the alu clock stays idle
  core_detachable_alu #(
    .USE_LI  (1'b0),
    .USE_INT (1'b1),
    .USE_MUL (1'b0),
    .USE_SFT (1'b1),
    .USE_CMP (1'b1)
  ) u_alu (
    .clk        (1'b0),
    .rst_n_i    (1'b1),
    .mul_i      ('0),
    .r0_i       (lane_i.r0),
    .r1_i       (lane_i.r1),
    .pc_i       ('0),
    .grand_op_i (lane_i.grand_op),
    .op_i       (lane_i.op),
    .res_o      (alu_res)
  );

  // every valid op commits
  assign wb_valid_o = lane_i.valid;
  assign wb_rd_o    = lane_i.rd;
  // rd 0 result squashed, so bypass and file only ever see zero there
  assign wb_data_o  = (lane_i.rd == '0) ? '0 : alu_res;

endmodule

/* design/operand_dispatch.sv */
`timescale 1ns/1ns

module operand_dispatch (
  input  logic                                                     clk,
  input  logic                                                     rst_n_i,
  input  cluster_pkg::issue_slot_t [cluster_pkg::LANES-1:0]        slots_i,
  input  logic [cluster_pkg::RF_RPORTS-1:0][alu_pkg::XLEN-1:0]     rf_data_i,
  output logic [cluster_pkg::RF_RPORTS-1:0][alu_pkg::REG_AW-1:0]   rf_addr_o,
  input  logic [cluster_pkg::LANES-1:0]                            wb_valid_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::REG_AW-1:0]       wb_rd_i,
  input  logic [cluster_pkg::LANES-1:0][alu_pkg::XLEN-1:0]         wb_data_i,
  lane_if.issue                                                    lane_o [cluster_pkg::LANES]
);
  import alu_pkg::*;
  import cluster_pkg::*;

  // file value unless a lane writes the same reg this cycle
  // scan upward so the highest writing lane wins
  function automatic logic [XLEN-1:0] bypass(
    input logic [REG_AW-1:0]             addr,
    input logic [XLEN-1:0]               rf_val,
    input logic [LANES-1:0]              wb_valid,
    input logic [LANES-1:0][REG_AW-1:0]  wb_rd,
    input logic [LANES-1:0][XLEN-1:0]    wb_data
  );
    logic [XLEN-1:0] val;
    val = rf_val;
    for (int l = 0; l < LANES; l++) begin
      if (wb_valid[l] && (wb_rd[l] == addr)) begin
        val = wb_data[l];
      end
    end
    return val;
  endfunction

  for (genvar s = 0; s < LANES; s++) begin : g_slot
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] opnd0;

    // even port rs1, odd port rs2
    assign rf_addr_o[2*s]   = slots_i[s].rs1;
    assign rf_addr_o[2*s+1] = slots_i[s].rs2;

    assign src1 = bypass(slots_i[s].rs1, rf_data_i[2*s], wb_valid_i, wb_rd_i, wb_data_i);
    assign src2 = bypass(slots_i[s].rs2, rf_data_i[2*s+1], wb_valid_i, wb_rd_i, wb_data_i);

    // immediate replaces rs2 as r0
    assign opnd0 = slots_i[s].use_imm ? slots_i[s].imm : src2;

    // issue stage, valid only
    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        lane_o[s].valid <= 1'b0;
      end else begin
        lane_o[s].valid <= slots_i[s].valid;
      end
    end

    // operand and control payload
    always_ff @(posedge clk) begin
      lane_o[s].grand_op <= slots_i[s].grand_op;
      lane_o[s].op       <= slots_i[s].op;
      lane_o[s].rd       <= slots_i[s].rd;
      lane_o[s].r0       <= opnd0;
      lane_o[s].r1       <= src1;
    end
  end

endmodule

/* design/core_detachable_alu.sv */
`timescale 1ns/1ns

module core_detachable_alu #(
  parameter bit USE_LI  = 1'b0,
  parameter bit USE_INT = 1'b1,
  parameter bit USE_MUL = 1'b0,
  parameter bit USE_SFT = 1'b1,
  parameter bit USE_CMP = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic [alu_pkg::XLEN-1:0] mul_i,
  input  logic [alu_pkg::XLEN-1:0] r0_i,
  input  logic [alu_pkg::XLEN-1:0] r1_i,
  input  logic [alu_pkg::XLEN-1:0] pc_i,
  input  logic [1:0]               grand_op_i,
  input  logic [1:0]               op_i,
  output logic [alu_pkg::XLEN-1:0] res_o
);
  import alu_pkg::*;

  logic [XLEN-1:0] g0_result;
  logic [XLEN-1:0] g1_result;
  logic [XLEN-1:0] g2_result;
  logic [XLEN-1:0] g3_result;
  logic [XLEN:0]   sub_r;
  logic [XLEN:0]   r1_ext;
  logic [XLEN:0]   r0_ext;
  logic            ext;

  // group select, disabled groups fall back to logic
  always_comb begin
    case (grand_op_i)
      GTYPE_LOGIC: res_o = g0_result;
      GTYPE_INT:   res_o = (USE_LI || USE_INT || USE_MUL) ? g1_result : g0_result;
      GTYPE_SFT:   res_o = USE_SFT ? g2_result : g0_result;
      GTYPE_CMP:   res_o = USE_CMP ? g3_result : g0_result;
      default:     res_o = g0_result;
    endcase
  end

  // logic group, always present
  always_comb begin
    case (op_i)
      STYPE_NOR: g0_result = ~(r1_i | r0_i);
      STYPE_AND: g0_result = r1_i & r0_i;
      STYPE_OR:  g0_result = r1_i | r0_i;
      default:   g0_result = r1_i ^ r0_i;
    endcase
  end

  // shared 33-bit subtract
  // inverted sign as extension gives signed order in bit XLEN
  assign ext    = ~op_i[0];
  assign r1_ext = {~r1_i[XLEN-1] & ext, r1_i};
  assign r0_ext = {~r0_i[XLEN-1] & ext, r0_i};
  assign sub_r  = r1_ext - r0_ext;

  // group 1, one alternative per build
  if (USE_INT) begin : g_int
    always_comb begin
      case (op_i)
        STYPE_ADD: g1_result = r1_i + r0_i;
        STYPE_SUB: g1_result = sub_r[XLEN-1:0];
        // remaining codes decode on bit 1 only
        default:   g1_result = op_i[1] ? sub_r[XLEN-1:0] : r1_i + r0_i;
      endcase
    end
  end else if (USE_LI) begin : g_li
    always_comb begin
      case (op_i)
        STYPE_LUI:     g1_result = {r0_i[XLEN-13:0], 12'd0};
        STYPE_PCPLUS4: g1_result = pc_i + XLEN'(4);
        STYPE_PCADDUI: g1_result = pc_i + r0_i;
        default:       g1_result = {r0_i[XLEN-13:0], 12'd0};
      endcase
    end
  end else if (USE_MUL) begin : g_mul
    logic [XLEN-1:0] mul_q;
    // product from the detached multiplier, captured at the edge
    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        mul_q <= '0;
      end else begin
        mul_q <= mul_i;
      end
    end
    assign g1_result = mul_q;
  end else begin : g_no_g1
    assign g1_result = '0;
  end

  // shifts by the low 5 bits of r0
  if (USE_SFT) begin : g_sft
    always_comb begin
      case (op_i)
        STYPE_SLL: g2_result = r1_i << r0_i[4:0];
        STYPE_SRL: g2_result = r1_i >> r0_i[4:0];
        STYPE_SRA: g2_result = $signed(r1_i) >>> r0_i[4:0];
        default:   g2_result = r1_i << r0_i[4:0];
      endcase
    end
  end else begin : g_no_sft
    assign g2_result = '0;
  end

  // set-less-than from the subtract borrow
  if (USE_CMP) begin : g_cmp
    always_comb begin
      g3_result = '0;
      case (op_i)
        STYPE_SLT, STYPE_SLTU: g3_result[0] = sub_r[XLEN];
        default:               g3_result[0] = 1'b0;
      endcase
    end
  end else begin : g_no_cmp
    assign g3_result = '0;
  end

endmodule

/* design/lane_if.sv */
`timescale 1ns/1ns

interface lane_if;
  import alu_pkg::*;

  // op is live in the lane this cycle
  logic              valid;
  logic [1:0]        grand_op;
  logic [1:0]        op;
  logic [REG_AW-1:0] rd;
  // second operand, imm already muxed in
  logic [XLEN-1:0]   r0;
  // first source operand
  logic [XLEN-1:0]   r1;

  // dispatch side, registered
  modport issue (
    output valid, grand_op, op, rd, r0, r1
  );

  // alu lane side
  modport exec (
    input valid, grand_op, op, rd, r0, r1
  );

endinterface

/* design/cluster_pkg.sv */
package cluster_pkg;

  // ops per bundle, one alu lane each
  localparam int LANES = 2;
  // architectural registers
  localparam int NREGS = 32;
  // two source reads per slot
  localparam int RF_RPORTS = 2 * LANES;

  // one slot of an issue bundle
  typedef struct packed {
    logic                       valid;
    logic [1:0]                 grand_op;
    logic [1:0]                 op;
    logic [alu_pkg::REG_AW-1:0] rd;
    logic [alu_pkg::REG_AW-1:0] rs1;
    logic [alu_pkg::REG_AW-1:0] rs2;
    // second operand comes from imm instead of rs2
    logic                       use_imm;
    logic [alu_pkg::XLEN-1:0]   imm;
  } issue_slot_t;

endpackage

/* design/alu_pkg.sv */
package alu_pkg;

  // datapath width
  localparam int XLEN = 32;
  // architectural register index width
  localparam int REG_AW = 5;

  // operation groups, grand_op field
  localparam logic [1:0] GTYPE_LOGIC = 2'b00;
  localparam logic [1:0] GTYPE_INT   = 2'b01;
  localparam logic [1:0] GTYPE_SFT   = 2'b10;
  localparam logic [1:0] GTYPE_CMP   = 2'b11;

  // logic group sub-ops
  localparam logic [1:0] STYPE_NOR = 2'b00;
  localparam logic [1:0] STYPE_AND = 2'b01;
  localparam logic [1:0] STYPE_OR  = 2'b10;
  localparam logic [1:0] STYPE_XOR = 2'b11;

  // integer group sub-ops
  // bit 1 picks the subtractor
  localparam logic [1:0] STYPE_ADD = 2'b00;
  localparam logic [1:0] STYPE_SUB = 2'b10;

  // load-immediate alternative of the integer group
  localparam logic [1:0] STYPE_LUI     = 2'b01;
  localparam logic [1:0] STYPE_PCPLUS4 = 2'b10;
  localparam logic [1:0] STYPE_PCADDUI = 2'b11;

  // shift group sub-ops
  localparam logic [1:0] STYPE_SLL = 2'b00;
  localparam logic [1:0] STYPE_SRL = 2'b01;
  localparam logic [1:0] STYPE_SRA = 2'b10;

  // compare group sub-ops
  // low bit clear selects signed extension in the shared subtract
  localparam logic [1:0] STYPE_SLT  = 2'b00;
  localparam logic [1:0] STYPE_SLTU = 2'b01;

endpackage
